// ==== verilog/rvvi_cfg.svh ====
//////////////////////////////
// RVVI trace configuration
// Register file sizes, data widths and the
// machine CSR addresses tracked by the converter
//////////////////////////////

`ifndef RVVI_CFG_SVH
`define RVVI_CFG_SVH

// Registers per file, integer and floating point alike
`define RVVI_NUM_REGS 32

// Integer and floating-point register widths
`define RVVI_XLEN 32
`define RVVI_FLEN 32

// Number of tracked CSR slots
`define RVVI_NUM_CSR 8

//////////////////////////////
// Machine CSR addresses
//////////////////////////////
`define RVVI_CSR_MSTATUS_ADDR  12'h300
`define RVVI_CSR_MISA_ADDR     12'h301
`define RVVI_CSR_MIE_ADDR      12'h304
`define RVVI_CSR_MTVEC_ADDR    12'h305
`define RVVI_CSR_MSCRATCH_ADDR 12'h340
`define RVVI_CSR_MEPC_ADDR     12'h341
`define RVVI_CSR_MCAUSE_ADDR   12'h342
`define RVVI_CSR_MIP_ADDR      12'h344

`endif

// ==== verilog/rvviPkg.sv ====
//////////////////////////////
// RVVI trace types
// Retirement input record, destination writes,
// CSR ports, CSR slot table and trace output
//////////////////////////////

`include "rvvi_cfg.svh"

package rvviPkg;

    //////////////////////////////
    // Retirement fields
    //////////////////////////////

    // 140 bits, low 6 reserved and kept at zero
    typedef struct packed {
        logic [63:0] order;
        logic [31:0] insn;
        logic        trap;
        logic        intr;
        logic [1:0]  mode;
        logic [1:0]  ixl;
        logic [31:0] pcRdata;
        logic [5:0]  rsvd;
    } retireT;

    // One integer destination write
    typedef struct packed {
        logic                    valid;
        logic [4:0]              addr;
        logic [`RVVI_XLEN-1:0]   data;
    } gprWriteT;

    // One floating-point destination write
    typedef struct packed {
        logic                    valid;
        logic [4:0]              addr;
        logic [`RVVI_FLEN-1:0]   data;
    } fprWriteT;

    // Raw CSR view from the retirement port
    typedef struct packed {
        logic [`RVVI_XLEN-1:0] wdata;
        logic [`RVVI_XLEN-1:0] rdata;
        logic [`RVVI_XLEN-1:0] wmask;
    } csrPortT;

    // Slot order of the tracked CSRs
    typedef enum logic [2:0] {
        csrMstatus,
        csrMisa,
        csrMie,
        csrMtvec,
        csrMscratch,
        csrMepc,
        csrMcause,
        csrMip
    } csrSlotT;

    // Slot to address lookup, indexed by csrSlotT
    localparam logic [11:0] csrAddrTable [`RVVI_NUM_CSR] = '{
        `RVVI_CSR_MSTATUS_ADDR,
        `RVVI_CSR_MISA_ADDR,
        `RVVI_CSR_MIE_ADDR,
        `RVVI_CSR_MTVEC_ADDR,
        `RVVI_CSR_MSCRATCH_ADDR,
        `RVVI_CSR_MEPC_ADDR,
        `RVVI_CSR_MCAUSE_ADDR,
        `RVVI_CSR_MIP_ADDR
    };

    //////////////////////////////
    // Full records
    //////////////////////////////

    // Input record from the core
    typedef struct packed {
        logic                              valid;
        retireT                            retire;
        gprWriteT [1:0]                    gpr;
        fprWriteT [1:0]                    fpr;
        csrPortT [`RVVI_NUM_CSR-1:0]       csr;
    } rvfiInT;

    // Trace record toward the checker
    typedef struct packed {
        logic                                          valid;
        retireT                                        retire;
        logic [`RVVI_NUM_REGS-1:0]                     xWb;
        logic [`RVVI_NUM_REGS-1:0][`RVVI_XLEN-1:0]     xWdata;
        logic [`RVVI_NUM_REGS-1:0]                     fWb;
        logic [`RVVI_NUM_REGS-1:0][`RVVI_FLEN-1:0]     fWdata;
        logic [`RVVI_NUM_CSR-1:0][`RVVI_XLEN-1:0]      csrVal;
        logic [`RVVI_NUM_CSR-1:0]                      csrWb;
    } rvviOutT;

endpackage

// ==== verilog/csrMerge.sv ====
//////////////////////////////
// CSR merge unit
// Forms each CSR value from write and read data
// under its mask, flags CSRs whose value changed
//////////////////////////////

`timescale 1ns/1ps

`include "rvvi_cfg.svh"

module csrMerge (
    input  logic                                      rvvi,
    input  logic                                      arstN_i,
    input  logic                                      valid_i,
    input  rvviPkg::csrPortT [`RVVI_NUM_CSR-1:0]      csr_i,
    output logic [`RVVI_NUM_CSR-1:0][`RVVI_XLEN-1:0]  csrVal_o,
    output logic [`RVVI_NUM_CSR-1:0]                  csrWb_o
);

    // Merged values of the current retirement
    logic [`RVVI_NUM_CSR-1:0][`RVVI_XLEN-1:0] merged;

    // Per-slot compare against the last retirement
    logic [`RVVI_NUM_CSR-1:0] changed;

    // Value of each CSR at the previous valid retirement
    logic [`RVVI_NUM_CSR-1:0][`RVVI_XLEN-1:0] shadowQ;

    // Registered changed flags
    logic [`RVVI_NUM_CSR-1:0] wbQ;

    //////////////////////////////
    // Merge and compare
    //////////////////////////////

    // Masked bits come from wdata, the rest from rdata
    always_comb begin
        for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
            merged[i] = (csr_i[i].wdata & csr_i[i].wmask)
                      | (csr_i[i].rdata & ~csr_i[i].wmask);
            changed[i] = (merged[i] != shadowQ[i]);
        end
    end

    //////////////////////////////
    // Shadow and flag registers
    //////////////////////////////

    // Shadow doubles as the registered value
    // Idle cycles leave both untouched
    always_ff @(posedge rvvi or negedge arstN_i) begin
        if (!arstN_i) begin
            shadowQ <= '0;
            wbQ     <= '0;
        end else if (valid_i) begin
            shadowQ <= merged;
            wbQ     <= changed;
        end
    end

    // Values seen by the assembler
    assign csrVal_o = shadowQ;
    assign csrWb_o  = wbQ;

endmodule

// ==== verilog/regWriteback.sv ====
//////////////////////////////
// Register write-back unit
// Turns two destination writes into a write-back
// mask and a value table for one register file
//////////////////////////////

`timescale 1ns/1ps

`include "rvvi_cfg.svh"

module regWriteback #(
    parameter type writeT        = rvviPkg::gprWriteT,
    parameter type dataT         = logic [`RVVI_XLEN-1:0],
    parameter bit  zeroHardwired = 1'b1
) (
    input  logic                             rvvi,
    input  logic                             arstN_i,
    input  logic                             valid_i,
    input  writeT [1:0]                      write_i,
    output logic [`RVVI_NUM_REGS-1:0]        wb_o,
    output dataT [`RVVI_NUM_REGS-1:0]        wdata_o
);

    // Next mask and table from the current retirement
    logic [`RVVI_NUM_REGS-1:0] wbNext;
    dataT [`RVVI_NUM_REGS-1:0] wdataNext;

    //////////////////////////////
    // Decode the two entries
    //////////////////////////////

    // Entry 1 is applied last so it wins on a shared address
    always_comb begin
        wbNext    = '0;
        wdataNext = '0;
        for (int k = 0; k < 2; k++) begin
            if (write_i[k].valid) begin
                // x0 style register never records a write
                if (!(zeroHardwired && (write_i[k].addr == '0))) begin
                    wbNext[write_i[k].addr]    = 1'b1;
                    wdataNext[write_i[k].addr] = write_i[k].data;
                end
            end
        end
    end

    //////////////////////////////
    // Output registers
    //////////////////////////////

    // Mask is cleared on reset
    always_ff @(posedge rvvi or negedge arstN_i) begin
        if (!arstN_i) begin
            wb_o <= '0;
        end else if (valid_i) begin
            wb_o <= wbNext;
        end
    end

    // Value table, loaded together with the mask
    always_ff @(posedge rvvi) begin
        if (valid_i) begin
            wdata_o <= wdataNext;
        end
    end

endmodule

// ==== verilog/traceAssemble.sv ====
//////////////////////////////
// Trace record assembler
// Delays the retirement fields one cycle and
// registers the complete trace record
//////////////////////////////

`timescale 1ns/1ps

`include "rvvi_cfg.svh"

module traceAssemble (
    input  logic                                       rvvi,
    input  logic                                       arstN_i,
    input  logic                                       valid_i,
    input  rvviPkg::retireT                            retire_i,
    input  logic [`RVVI_NUM_REGS-1:0]                  xWb_i,
    input  logic [`RVVI_NUM_REGS-1:0][`RVVI_XLEN-1:0]  xWdata_i,
    input  logic [`RVVI_NUM_REGS-1:0]                  fWb_i,
    input  logic [`RVVI_NUM_REGS-1:0][`RVVI_FLEN-1:0]  fWdata_i,
    input  logic [`RVVI_NUM_CSR-1:0][`RVVI_XLEN-1:0]   csrVal_i,
    input  logic [`RVVI_NUM_CSR-1:0]                   csrWb_i,
    output rvviPkg::rvviOutT                           trace_o
);

    // First stage, lines up with the side units
    logic            validQ;
    rvviPkg::retireT retireQ;

    always_ff @(posedge rvvi or negedge arstN_i) begin
        if (!arstN_i) begin
            validQ <= 1'b0;
        end else begin
            validQ <= valid_i;
        end
    end

    always_ff @(posedge rvvi) begin
        retireQ <= retire_i;
    end

    //////////////////////////////
    // Output record
    //////////////////////////////

    // Valid tracks every cycle, payload only on a live record
    always_ff @(posedge rvvi or negedge arstN_i) begin
        if (!arstN_i) begin
            trace_o <= '0;
        end else begin
            trace_o.valid <= validQ;
            if (validQ) begin
                trace_o.retire      <= retireQ;
                // Reserved bits leave as zero
                trace_o.retire.rsvd <= '0;
                trace_o.xWb         <= xWb_i;
                trace_o.xWdata      <= xWdata_i;
                trace_o.fWb         <= fWb_i;
                trace_o.fWdata      <= fWdata_i;
                trace_o.csrVal      <= csrVal_i;
                trace_o.csrWb       <= csrWb_i;
            end
        end
    end

endmodule

// ==== verilog/rvviTraceTop.sv ====
//////////////////////////////
// Retirement trace converter
// Core retirement record in, verification trace
// record out, two cycles later
//////////////////////////////

`timescale 1ns/1ps

`include "rvvi_cfg.svh"

module rvviTraceTop (
    input  logic              rvvi,
    input  logic              arstN_i,
    input  rvviPkg::rvfiInT   rvfi_i,
    output rvviPkg::rvviOutT  trace_o
);

    // Side unit results, one cycle after the input
    logic [`RVVI_NUM_REGS-1:0]                  xWb;
    logic [`RVVI_NUM_REGS-1:0][`RVVI_XLEN-1:0]  xWdata;
    logic [`RVVI_NUM_REGS-1:0]                  fWb;
    logic [`RVVI_NUM_REGS-1:0][`RVVI_FLEN-1:0]  fWdata;
    logic [`RVVI_NUM_CSR-1:0][`RVVI_XLEN-1:0]   csrVal;
    logic [`RVVI_NUM_CSR-1:0]                   csrWb;

    //////////////////////////////
    // Side units
    //////////////////////////////

    csrMerge csrMerge_i (
        .rvvi     (rvvi),
        .arstN_i  (arstN_i),
        .valid_i  (rvfi_i.valid),
        .csr_i    (rvfi_i.csr),
        .csrVal_o (csrVal),
        .csrWb_o  (csrWb)
    );

    // Integer file, x0 is hardwired
    regWriteback #(
        .writeT        (rvviPkg::gprWriteT),
        .dataT         (logic [`RVVI_XLEN-1:0]),
        .zeroHardwired (1'b1)
    ) gprWb_i (
        .rvvi    (rvvi),
        .arstN_i (arstN_i),
        .valid_i (rvfi_i.valid),
        .write_i (rvfi_i.gpr),
        .wb_o    (xWb),
        .wdata_o (xWdata)
    );

    // Floating-point file, f0 is a real register
    regWriteback #(
        .writeT        (rvviPkg::fprWriteT),
        .dataT         (logic [`RVVI_FLEN-1:0]),
        .zeroHardwired (1'b0)
    ) fprWb_i (
        .rvvi    (rvvi),
        .arstN_i (arstN_i),
        .valid_i (rvfi_i.valid),
        .write_i (rvfi_i.fpr),
        .wb_o    (fWb),
        .wdata_o (fWdata)
    );

    //////////////////////////////
    // Record assembly
    //////////////////////////////

    traceAssemble traceAssemble_i (
        .rvvi     (rvvi),
        .arstN_i  (arstN_i),
        .valid_i  (rvfi_i.valid),
        .retire_i (rvfi_i.retire),
        .xWb_i    (xWb),
        .xWdata_i (xWdata),
        .fWb_i    (fWb),
        .fWdata_i (fWdata),
        .csrVal_i (csrVal),
        .csrWb_i  (csrWb),
        .trace_o  (trace_o)
    );

endmodule

// ==== dv/rvviTrace_props.sv ====
//////////////////////////////
// Trace converter properties
// Port level timing and reset checks
//////////////////////////////

`timescale 1ns/1ps

module rvviTraceProps (
    input logic              rvvi,
    input logic              arstN_i,
    input rvviPkg::rvfiInT   rvfi_i,
    input rvviPkg::rvviOutT  trace_o
);

    // Number of failed assertions
    int failCount = 0;

    // Output valid two edges behind the input
    validLatency: assert property (@(posedge rvvi) disable iff (!arstN_i)
        trace_o.valid == $past(rvfi_i.valid, 2))
        else begin
            failCount++;
            $error("output valid does not follow input valid by two edges");
        end

    // x0 never shows a write
    noX0Write: assert property (@(posedge rvvi) !trace_o.xWb[0])
        else begin
            failCount++;
            $error("xWb bit 0 set");
        end

    // Quiet output while in reset
    resetQuiet: assert property (@(posedge rvvi) !arstN_i |-> !trace_o.valid)
        else begin
            failCount++;
            $error("output valid high during reset");
        end

endmodule

bind rvviTraceTop rvviTraceProps rvviTraceProps_i (
    .rvvi    (rvvi),
    .arstN_i (arstN_i),
    .rvfi_i  (rvfi_i),
    .trace_o (trace_o)
);

// ==== dv/rvviTraceTb.sv ====
//////////////////////////////
// Retirement trace testbench
// Directed tests and a random stream against
// a software model of the converter
//////////////////////////////

`timescale 1ns/1ps

`include "rvvi_cfg.svh"

module rvviTraceTb;

    // Upper bound of records driven, sizes the watchdog
    localparam int plannedRecords = 60;

    logic              rvvi;
    logic              arstN_i;
    rvviPkg::rvfiInT   rvfi_i;
    rvviPkg::rvviOutT  trace_o;

    int                errCount;
    int                checkCount;
    int                driven;
    logic [31:0]       lfsrState;

    // Expected records, two entries ahead of the output
    rvviPkg::rvviOutT  expQ[$];

    // CSR values at the last valid retirement
    logic [`RVVI_NUM_CSR-1:0][`RVVI_XLEN-1:0] shadow;

    rvviTraceTop rvviTraceTop_i (
        .rvvi    (rvvi),
        .arstN_i (arstN_i),
        .rvfi_i  (rvfi_i),
        .trace_o (trace_o)
    );

    // 4 ns clock
    always begin
        rvvi = 1'b0;
        #2;
        rvvi = 1'b1;
        #2;
    end

    //////////////////////////////
    // Random bits
    //////////////////////////////

    // Taps 32 22 2 1
    function automatic logic lfsrBit();
        logic newBit;
        newBit    = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], newBit};
        return newBit;
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsrBit()};
        end
        return r;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic rvviPkg::rvviOutT modelRecord(rvviPkg::rvfiInT rec);
        rvviPkg::rvviOutT o;
        logic [`RVVI_XLEN-1:0] m;
        o = '0;
        o.valid = rec.valid;
        if (!rec.valid) begin
            return o;
        end
        o.retire = rec.retire;
        o.retire.rsvd = '0;
        for (int k = 0; k < 2; k++) begin
            // Later entry overwrites, x0 never recorded
            if (rec.gpr[k].valid && rec.gpr[k].addr != 0) begin
                o.xWb[rec.gpr[k].addr] = 1'b1;
                o.xWdata[rec.gpr[k].addr] = rec.gpr[k].data;
            end
            if (rec.fpr[k].valid) begin
                o.fWb[rec.fpr[k].addr] = 1'b1;
                o.fWdata[rec.fpr[k].addr] = rec.fpr[k].data;
            end
        end
        for (int c = 0; c < `RVVI_NUM_CSR; c++) begin
            // Bit by bit pick from wdata or rdata
            for (int b = 0; b < `RVVI_XLEN; b++) begin
                m[b] = rec.csr[c].wmask[b] ? rec.csr[c].wdata[b] : rec.csr[c].rdata[b];
            end
            o.csrWb[c] = (m != shadow[c]);
            o.csrVal[c] = m;
            shadow[c] = m;
        end
        return o;
    endfunction

    //////////////////////////////
    // Checks and stepping
    //////////////////////////////

    task automatic checkValue(string name, logic [1023:0] expVal, logic [1023:0] actVal);
        checkCount++;
        if (expVal !== actVal) begin
            errCount++;
            $display("CHECK FAILED at %0t ns: %s expected %0h actual %0h",
                     $time, name, expVal, actVal);
        end
    endtask

    // Checks the output due now, then drives the next record
    task automatic stepRecord(rvviPkg::rvfiInT rec);
        rvviPkg::rvviOutT e;
        @(posedge rvvi);
        #1;
        e = expQ.pop_front();
        checkValue("trace_o.valid", 1024'(e.valid), 1024'(trace_o.valid));
        if (e.valid) begin
            checkValue("trace_o.retire", 1024'(e.retire), 1024'(trace_o.retire));
            checkValue("trace_o.xWb", 1024'(e.xWb), 1024'(trace_o.xWb));
            checkValue("trace_o.xWdata", e.xWdata, trace_o.xWdata);
            checkValue("trace_o.fWb", 1024'(e.fWb), 1024'(trace_o.fWb));
            checkValue("trace_o.fWdata", e.fWdata, trace_o.fWdata);
            checkValue("trace_o.csrVal", 1024'(e.csrVal), 1024'(trace_o.csrVal));
            checkValue("trace_o.csrWb", 1024'(e.csrWb), 1024'(trace_o.csrWb));
        end
        rvfi_i = rec;
        expQ.push_back(modelRecord(rec));
        driven++;
    endtask

    // Valid record with random retirement fields and no writes
    function automatic rvviPkg::rvfiInT baseRecord();
        rvviPkg::rvfiInT r;
        r = '0;
        r.valid = 1'b1;
        r.retire.order = {randBits(32), randBits(32)};
        r.retire.insn = randBits(32);
        r.retire.trap = 1'(randBits(1));
        r.retire.intr = 1'(randBits(1));
        r.retire.mode = 2'(randBits(2));
        r.retire.ixl = 2'(randBits(2));
        r.retire.pcRdata = randBits(32);
        return r;
    endfunction

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic resetTest();
        rvfi_i = '0;
        // Falling edge of reset after the flops are waiting on it
        #1;
        arstN_i = 1'b0;
        repeat (10) @(posedge rvvi);
        #1;
        arstN_i = 1'b1;
        checkValue("trace_o.valid", '0, 1024'(trace_o.valid));
        checkValue("trace_o.xWb", '0, 1024'(trace_o.xWb));
        checkValue("trace_o.fWb", '0, 1024'(trace_o.fWb));
        checkValue("trace_o.csrWb", '0, 1024'(trace_o.csrWb));
        // Output pipeline starts empty
        expQ.push_back('0);
        expQ.push_back('0);
    endtask

    task automatic gprTest();
        rvviPkg::rvfiInT r;
        r = baseRecord();
        r.gpr[0] = '{valid: 1'b1, addr: 5'd5, data: randBits(32)};
        stepRecord(r);
        r = baseRecord();
        r.gpr[1] = '{valid: 1'b1, addr: 5'd0, data: randBits(32)};
        stepRecord(r);
    endtask

    task automatic sameAddrTest();
        rvviPkg::rvfiInT r;
        r = baseRecord();
        r.gpr[0] = '{valid: 1'b1, addr: 5'd7, data: 32'h1111_0000};
        r.gpr[1] = '{valid: 1'b1, addr: 5'd7, data: 32'h2222_ffff};
        r.fpr[0] = '{valid: 1'b0, addr: 5'd3, data: randBits(32)};
        stepRecord(r);
        r = baseRecord();
        r.fpr[1] = '{valid: 1'b1, addr: 5'd0, data: randBits(32)};
        stepRecord(r);
    endtask

    task automatic csrTest();
        rvviPkg::rvfiInT r;
        r = baseRecord();
        for (int c = 0; c < `RVVI_NUM_CSR; c++) begin
            r.csr[c] = {randBits(32), randBits(32), randBits(32)};
        end
        stepRecord(r);
        // Same CSR values again, no flag expected
        r.retire.order = r.retire.order + 1;
        stepRecord(r);
        r.csr[rvviPkg::csrMepc].wdata = ~r.csr[rvviPkg::csrMepc].wdata;
        r.csr[rvviPkg::csrMepc].wmask = '1;
        stepRecord(r);
    endtask

    task automatic streamTest();
        rvviPkg::rvfiInT r;
        for (int n = 0; n < 40; n++) begin
            r = baseRecord();
            r.valid = (randBits(2) != 0);
            for (int k = 0; k < 2; k++) begin
                r.gpr[k] = {1'(randBits(1)), 5'(randBits(5)), randBits(32)};
                r.fpr[k] = {1'(randBits(1)), 5'(randBits(5)), randBits(32)};
            end
            for (int c = 0; c < `RVVI_NUM_CSR; c++) begin
                r.csr[c] = {randBits(32), randBits(32), randBits(32)};
            end
            stepRecord(r);
        end
        // Drain the pipeline
        stepRecord('0);
        stepRecord('0);
    endtask

    // Watchdog, 2 us plus 8 ns per record
    initial begin
        #(2000 + 8 * plannedRecords);
        $display("Timeout: the run did not finish in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        errCount = 0;
        checkCount = 0;
        driven = 0;
        lfsrState = 32'h7779_bf80;
        shadow = '0;
        arstN_i = 1'b1;
        rvfi_i = '0;
        resetTest();
        gprTest();
        sameAddrTest();
        csrTest();
        streamTest();
        // Failed assertions count as errors too
        errCount = errCount + rvviTraceTop_i.rvviTraceProps_i.failCount;
        $display("%0d errors in %0d checks over %0d records", errCount, checkCount, driven);
        if (errCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/rvviPkg.sv
verilog/csrMerge.sv
verilog/regWriteback.sv
verilog/traceAssemble.sv
verilog/rvviTraceTop.sv
dv/rvviTrace_props.sv
dv/rvviTraceTb.sv

// ==== Makefile ====
# Verilator build and run of the trace converter testbench

VERILATOR ?= verilator
TOP       ?= rvviTraceTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
